// ==== Bender.yml ====
package:
  name: mem_unit

sources:
  - include_dirs:
      - logic
    files:
      - logic/mu_pkg.sv
      - logic/mu_ctrl_fsm.sv
      - logic/mu_cmd_gen.sv
      - logic/mu_wb_tag.sv
      - logic/mu_load_ext.sv
      - logic/mu_top.sv
  - target: simulation
    files:
      - verification/dbus_mem_model.sv
      - verification/mu_tb.sv

// ==== logic/mu_cmd_gen.sv ====
// Data bus command builder, turns the issued operation into address, size, data and valid
`timescale 1ns/1ps

module mu_cmd_gen (
   input  logic          ieu_mu_in_valid,
   input  mu_pkg::data_t ieu_operand_1,
   input  mu_pkg::data_t ieu_operand_2,
   input  mu_pkg::data_t ieu_operand_3,
   input  logic          ieu_mu_load,
   input  logic          ieu_mu_store,
   input  mu_pkg::size_t ieu_mu_load_size,
   input  mu_pkg::size_t ieu_mu_store_size,
   output logic          dbus_cmd_valid,
   output mu_pkg::addr_t dbus_cmd_addr,
   output mu_pkg::size_t dbus_cmd_size,
   output logic          dbus_cmd_we,
   output mu_pkg::data_t dbus_din,
   output logic          mu_op_nxt
);

   mu_pkg::data_t ea_sum;

   // Effective address is base plus offset
   assign ea_sum        = ieu_operand_1 + ieu_operand_2;
   assign dbus_cmd_addr = mu_pkg::addr_t'(ea_sum);

   // Stores write operand 3 as is
   // no lane steering here
   assign dbus_cmd_we = ieu_mu_store;
   assign dbus_din    = ieu_operand_3;

   // Size follows the op kind
   always_comb begin
      dbus_cmd_size = '0;
      if (ieu_mu_load) begin
         dbus_cmd_size = dbus_cmd_size | ieu_mu_load_size;
      end
      if (ieu_mu_store) begin
         dbus_cmd_size = dbus_cmd_size | ieu_mu_store_size;
      end
   end

   // Load or store needs the bus
   assign mu_op_nxt = ieu_mu_load | ieu_mu_store;

   // Only memory ops reach the bus
   assign dbus_cmd_valid = ieu_mu_in_valid & mu_op_nxt;

endmodule

// ==== logic/mu_ctrl_fsm.sv ====
// Memory unit controller, tracks the single outstanding bus transaction and gates issue ready
`timescale 1ns/1ps

module mu_ctrl_fsm (
   input  logic              clk,
   input  logic              rst,
   input  logic              dbus_cmd_ready,
   input  logic              dbus_cmd_valid,
   input  logic              wb_mu_in_valid,
   input  logic              wb_mu_in_ready,
   input  logic              ieu_mu_in_valid,
   output logic              ieu_mu_in_ready,
   output mu_pkg::mu_state_e state,
   output logic              cmd_accept,
   output logic              issue_accept
);

   mu_pkg::mu_state_e state_nxt;
   logic              wb_accept;

   // Handshakes on the three channels
   assign cmd_accept   = dbus_cmd_valid & dbus_cmd_ready;
   assign issue_accept = ieu_mu_in_valid & ieu_mu_in_ready;
   assign wb_accept    = wb_mu_in_valid & wb_mu_in_ready;

   // Accept new ops only with the bus free and nothing pending
   assign ieu_mu_in_ready = dbus_cmd_ready & (state == mu_pkg::MU_IDLE);

   // Next state
   always_comb begin
      state_nxt = state;
      case (state)
         mu_pkg::MU_IDLE: begin
            // Command taken by the bus
            if (cmd_accept) begin
               state_nxt = mu_pkg::MU_PENDING;
            end
         end
         mu_pkg::MU_PENDING: begin
            // Response handed to writeback
            if (wb_accept) begin
               state_nxt = mu_pkg::MU_IDLE;
            end
         end
         default: state_nxt = mu_pkg::MU_IDLE;
      endcase
   end

   // State register
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= mu_pkg::MU_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

endmodule

// ==== logic/mu_defs.svh ====
// Field width macros for the memory unit, included by the package and by RTL that sizes vectors
`ifndef MU_DEFS_SVH
`define MU_DEFS_SVH

// Effective address presented on the data bus
`define MU_AW 32

// Operand, store data and load data
`define MU_DW 32

// Register file index carried as the writeback tag
`define MU_REG_AW 5

// Low half and low byte of a data word
`define MU_HALF_W 16
`define MU_BYTE_W 8

`endif

// ==== logic/mu_load_ext.sv ====
// Load data formatter, holds the access size and extends the returned bus word
`timescale 1ns/1ps

`include "mu_defs.svh"

module mu_load_ext (
   input  logic          clk,
   input  logic          rst,
   input  logic          cmd_accept,
   input  mu_pkg::size_t ieu_mu_load_size,
   input  logic          ieu_mu_sign_ext,
   input  mu_pkg::data_t dbus_dout,
   output mu_pkg::data_t mu_load
);

   mu_pkg::size_t load_size_q;
   logic          sign_ext_q;
   logic          half_fill;
   logic          byte_fill;

   // Size and sign of the access in flight
   always_ff @(posedge clk) begin
      if (rst) begin
         load_size_q <= '0;
         sign_ext_q  <= 1'b0;
      end else if (cmd_accept) begin
         load_size_q <= ieu_mu_load_size;
         sign_ext_q  <= ieu_mu_sign_ext;
      end
   end

   // Fill bits for the upper part
   assign half_fill = sign_ext_q & dbus_dout[`MU_HALF_W-1];
   assign byte_fill = sign_ext_q & dbus_dout[`MU_BYTE_W-1];

   // Data always taken from the low bits
   always_comb begin
      case (load_size_q)
         mu_pkg::SIZE_WORD: mu_load = dbus_dout;
         mu_pkg::SIZE_HALF: begin
            mu_load = {{(`MU_DW-`MU_HALF_W){half_fill}}, dbus_dout[`MU_HALF_W-1:0]};
         end
         mu_pkg::SIZE_BYTE: begin
            mu_load = {{(`MU_DW-`MU_BYTE_W){byte_fill}}, dbus_dout[`MU_BYTE_W-1:0]};
         end
         // Unknown size code yields zero
         default: mu_load = '0;
      endcase
   end

endmodule

// ==== logic/mu_pkg.sv ====
// Shared memory unit types, referenced by scoped name from every RTL file of the unit
`include "mu_defs.svh"

package mu_pkg;

   // Width carrying vectors
   typedef logic [`MU_AW-1:0]     addr_t;
   typedef logic [`MU_DW-1:0]     data_t;
   typedef logic [`MU_REG_AW-1:0] reg_addr_t;

   // Access size code as seen on the bus
   typedef logic [2:0] size_t;

   // Size encodings
   localparam size_t SIZE_BYTE = 3'd1;
   localparam size_t SIZE_HALF = 3'd2;
   localparam size_t SIZE_WORD = 3'd3;

   // Controller states
   // Only one bus transaction may be in flight
   typedef enum logic {
      MU_IDLE    = 1'b0,
      MU_PENDING = 1'b1
   } mu_state_e;

endpackage

// ==== logic/mu_top.sv ====
// Memory unit top level, connects issue, data bus and writeback ports to the unit's blocks
`timescale 1ns/1ps

module mu_top (
   input  logic              clk,
   input  logic              rst,
   // Bus command channel
   input  logic              dbus_cmd_ready,
   output logic              dbus_cmd_valid,
   output mu_pkg::addr_t     dbus_cmd_addr,
   output mu_pkg::size_t     dbus_cmd_size,
   output logic              dbus_cmd_we,
   output mu_pkg::data_t     dbus_din,
   // Bus response channel
   output logic              dbus_ready,
   input  logic              dbus_valid,
   input  mu_pkg::data_t     dbus_dout,
   // Issue side
   output logic              ieu_mu_in_ready,
   input  logic              ieu_mu_in_valid,
   input  mu_pkg::data_t     ieu_operand_1,
   input  mu_pkg::data_t     ieu_operand_2,
   input  mu_pkg::data_t     ieu_operand_3,
   input  logic              ieu_mu_load,
   input  logic              ieu_mu_store,
   input  logic              ieu_mu_sign_ext,
   input  mu_pkg::size_t     ieu_mu_store_size,
   input  mu_pkg::size_t     ieu_mu_load_size,
   input  logic              ieu_wb_regf,
   input  mu_pkg::reg_addr_t ieu_wb_reg_addr,
   // Writeback side
   output logic              mu_op,
   output logic              mu_op_load,
   output logic              mu_wb_regf,
   output mu_pkg::reg_addr_t mu_wb_reg_addr,
   output mu_pkg::data_t     mu_load,
   input  logic              wb_mu_in_ready,
   output logic              wb_mu_in_valid
);

   mu_pkg::mu_state_e state;
   logic              cmd_accept;
   logic              issue_accept;
   logic              mu_op_nxt;

   // Response goes straight to writeback
   assign dbus_ready     = wb_mu_in_ready;
   assign wb_mu_in_valid = dbus_valid;

   // Controller
   mu_ctrl_fsm u_ctrl_fsm (
      .clk             (clk),
      .rst             (rst),
      .dbus_cmd_ready  (dbus_cmd_ready),
      .dbus_cmd_valid  (dbus_cmd_valid),
      .wb_mu_in_valid  (wb_mu_in_valid),
      .wb_mu_in_ready  (wb_mu_in_ready),
      .ieu_mu_in_valid (ieu_mu_in_valid),
      .ieu_mu_in_ready (ieu_mu_in_ready),
      .state           (state),
      .cmd_accept      (cmd_accept),
      .issue_accept    (issue_accept)
   );

   // Bus command
   mu_cmd_gen u_cmd_gen (
      .ieu_mu_in_valid   (ieu_mu_in_valid),
      .ieu_operand_1     (ieu_operand_1),
      .ieu_operand_2     (ieu_operand_2),
      .ieu_operand_3     (ieu_operand_3),
      .ieu_mu_load       (ieu_mu_load),
      .ieu_mu_store      (ieu_mu_store),
      .ieu_mu_load_size  (ieu_mu_load_size),
      .ieu_mu_store_size (ieu_mu_store_size),
      .dbus_cmd_valid    (dbus_cmd_valid),
      .dbus_cmd_addr     (dbus_cmd_addr),
      .dbus_cmd_size     (dbus_cmd_size),
      .dbus_cmd_we       (dbus_cmd_we),
      .dbus_din          (dbus_din),
      .mu_op_nxt         (mu_op_nxt)
   );

   // Writeback tag
   mu_wb_tag u_wb_tag (
      .clk             (clk),
      .rst             (rst),
      .issue_accept    (issue_accept),
      .state           (state),
      .mu_op_nxt       (mu_op_nxt),
      .ieu_mu_load     (ieu_mu_load),
      .ieu_wb_regf     (ieu_wb_regf),
      .ieu_wb_reg_addr (ieu_wb_reg_addr),
      .mu_op           (mu_op),
      .mu_op_load      (mu_op_load),
      .mu_wb_regf      (mu_wb_regf),
      .mu_wb_reg_addr  (mu_wb_reg_addr)
   );

   // Load data extension
   mu_load_ext u_load_ext (
      .clk              (clk),
      .rst              (rst),
      .cmd_accept       (cmd_accept),
      .ieu_mu_load_size (ieu_mu_load_size),
      .ieu_mu_sign_ext  (ieu_mu_sign_ext),
      .dbus_dout        (dbus_dout),
      .mu_load          (mu_load)
   );

endmodule

// ==== logic/mu_wb_tag.sv ====
// Writeback tag holder, keeps the tag of the outstanding op and shows live values otherwise
`timescale 1ns/1ps

module mu_wb_tag (
   input  logic              clk,
   input  logic              rst,
   input  logic              issue_accept,
   input  mu_pkg::mu_state_e state,
   input  logic              mu_op_nxt,
   input  logic              ieu_mu_load,
   input  logic              ieu_wb_regf,
   input  mu_pkg::reg_addr_t ieu_wb_reg_addr,
   output logic              mu_op,
   output logic              mu_op_load,
   output logic              mu_wb_regf,
   output mu_pkg::reg_addr_t mu_wb_reg_addr
);

   logic              mu_op_q;
   logic              mu_op_load_q;
   logic              mu_wb_regf_q;
   mu_pkg::reg_addr_t mu_wb_reg_addr_q;
   logic              pending;

   // Op flags captured with the issued op
   always_ff @(posedge clk) begin
      if (rst) begin
         mu_op_q      <= 1'b0;
         mu_op_load_q <= 1'b0;
         mu_wb_regf_q <= 1'b0;
      end else if (issue_accept) begin
         mu_op_q      <= mu_op_nxt;
         mu_op_load_q <= ieu_mu_load;
         mu_wb_regf_q <= ieu_wb_regf;
      end
   end

   // Register index captured alongside
   always_ff @(posedge clk) begin
      if (issue_accept) begin
         mu_wb_reg_addr_q <= ieu_wb_reg_addr;
      end
   end

   assign pending = (state == mu_pkg::MU_PENDING);

   // Pending op owns the writeback tag
   // Idle passes the issue side through
   assign mu_op          = pending ? mu_op_q          : mu_op_nxt;
   assign mu_op_load     = pending ? mu_op_load_q     : ieu_mu_load;
   assign mu_wb_regf     = pending ? mu_wb_regf_q     : ieu_wb_regf;
   assign mu_wb_reg_addr = pending ? mu_wb_reg_addr_q : ieu_wb_reg_addr;

endmodule

// ==== mem_unit.f ====
+incdir+logic
logic/mu_pkg.sv
logic/mu_ctrl_fsm.sv
logic/mu_cmd_gen.sv
logic/mu_wb_tag.sv
logic/mu_load_ext.sv
logic/mu_top.sv
verification/dbus_mem_model.sv
verification/mu_tb.sv

// ==== verification/dbus_mem_model.sv ====
// Behavioral data bus memory for the testbench, one transaction at a time with random delay
`timescale 1ns/1ps

module dbus_mem_model #(
   parameter int          DEPTH = 256,
   parameter logic [31:0] SEED  = 32'h1
) (
   input  logic          clk,
   input  logic          rst,
   input  logic          dbus_cmd_valid,
   output logic          dbus_cmd_ready,
   input  mu_pkg::addr_t dbus_cmd_addr,
   input  mu_pkg::size_t dbus_cmd_size,
   input  logic          dbus_cmd_we,
   input  mu_pkg::data_t dbus_din,
   output logic          dbus_valid,
   input  logic          dbus_ready,
   output mu_pkg::data_t dbus_dout
);

   localparam int IW = $clog2(DEPTH);

   mu_pkg::data_t mem [DEPTH];
   mu_pkg::data_t rsp_data;
   logic          busy;
   logic [1:0]    delay_cnt;
   logic [IW-1:0] idx;
   integer        seed;
   integer        i;

   // Initial contents depend on the full byte address of each word
   function automatic mu_pkg::data_t fill_word(input int unsigned word_idx);
      logic [31:0] byte_addr;
      begin
         byte_addr = word_idx << 2;
         fill_word = (byte_addr * 32'h9E3779B1) ^ 32'h3C6EF372;
      end
   endfunction

   initial begin
      seed = SEED;
      for (i = 0; i < DEPTH; i++) begin
         mem[i] = fill_word(i);
      end
   end

   // Word index from the bits above the byte offset
   assign idx = dbus_cmd_addr[IW+1:2];

   // Only one command accepted until its response is taken
   assign dbus_cmd_ready = ~busy;

   always @(posedge clk) begin
      if (rst) begin
         busy       <= 1'b0;
         dbus_valid <= 1'b0;
         dbus_dout  <= '0;
         delay_cnt  <= '0;
         rsp_data   <= '0;
      end else if (dbus_cmd_valid && dbus_cmd_ready) begin
         busy      <= 1'b1;
         delay_cnt <= $random(seed) & 3;
         // Whole word written, whole word read
         if (dbus_cmd_we) begin
            mem[idx] <= dbus_din;
            rsp_data <= '0;
         end else begin
            rsp_data <= mem[idx];
         end
      end else if (busy && !dbus_valid) begin
         if (delay_cnt == 0) begin
            dbus_valid <= 1'b1;
            dbus_dout  <= rsp_data;
         end else begin
            delay_cnt <= delay_cnt - 1'b1;
         end
      end else if (dbus_valid && dbus_ready) begin
         // Response held until taken
         dbus_valid <= 1'b0;
         busy       <= 1'b0;
      end
   end

endmodule

// ==== verification/mu_tb.sv ====
// Testbench for the memory unit top level, run from the file list with mu_tb as top
`timescale 1ns/1ps

module mu_tb;

   localparam int          DEPTH    = 256;
   localparam int          TMO      = 200;
   localparam logic [31:0] TB_SEED  = 32'h168041f5;

   typedef struct packed {
      logic              load;
      logic              regf;
      mu_pkg::reg_addr_t tag;
      mu_pkg::data_t     data;
   } exp_t;

   logic              clk;
   logic              rst;
   logic              dbus_cmd_ready;
   logic              dbus_cmd_valid;
   mu_pkg::addr_t     dbus_cmd_addr;
   mu_pkg::size_t     dbus_cmd_size;
   logic              dbus_cmd_we;
   mu_pkg::data_t     dbus_din;
   logic              dbus_ready;
   logic              dbus_valid;
   mu_pkg::data_t     dbus_dout;
   logic              ieu_mu_in_ready;
   logic              ieu_mu_in_valid;
   mu_pkg::data_t     ieu_operand_1;
   mu_pkg::data_t     ieu_operand_2;
   mu_pkg::data_t     ieu_operand_3;
   logic              ieu_mu_load;
   logic              ieu_mu_store;
   logic              ieu_mu_sign_ext;
   mu_pkg::size_t     ieu_mu_store_size;
   mu_pkg::size_t     ieu_mu_load_size;
   logic              ieu_wb_regf;
   mu_pkg::reg_addr_t ieu_wb_reg_addr;
   logic              mu_op;
   logic              mu_op_load;
   logic              mu_wb_regf;
   mu_pkg::reg_addr_t mu_wb_reg_addr;
   mu_pkg::data_t     mu_load;
   logic              wb_mu_in_ready;
   logic              wb_mu_in_valid;

   integer            seed;
   integer            stall_seed;
   integer            err_count;
   integer            timeout_count;
   integer            k;
   logic              hold_wb;
   logic              hold_valid;
   mu_pkg::data_t     held_load;
   mu_pkg::data_t     mirror [DEPTH];
   exp_t              exp_q [$];
   // Address and size the current memory op is meant to reach
   mu_pkg::addr_t     cur_addr;
   mu_pkg::size_t     cur_size;

   mu_top uut (.*);

   dbus_mem_model #(.DEPTH(DEPTH), .SEED(TB_SEED)) u_mem (
      .clk            (clk),
      .rst            (rst),
      .dbus_cmd_valid (dbus_cmd_valid),
      .dbus_cmd_ready (dbus_cmd_ready),
      .dbus_cmd_addr  (dbus_cmd_addr),
      .dbus_cmd_size  (dbus_cmd_size),
      .dbus_cmd_we    (dbus_cmd_we),
      .dbus_din       (dbus_din),
      .dbus_valid     (dbus_valid),
      .dbus_ready     (dbus_ready),
      .dbus_dout      (dbus_dout)
   );

   task automatic report_fail(input string msg);
      begin
         err_count++;
         $display("Fail at %0t: %s", $time, msg);
      end
   endtask

   task automatic report_timeout(input string what);
      begin
         timeout_count++;
         $display("Timed out at %0t while waiting for %s", $time, what);
      end
   endtask

   // Expected load result from the size and sign rules
   function automatic mu_pkg::data_t extend(input mu_pkg::data_t w, input mu_pkg::size_t sz,
                                            input logic sx);
      begin
         case (sz)
            mu_pkg::SIZE_WORD: extend = w;
            mu_pkg::SIZE_HALF: extend = {{16{sx & w[15]}}, w[15:0]};
            mu_pkg::SIZE_BYTE: extend = {{24{sx & w[7]}}, w[7:0]};
            default:           extend = '0;
         endcase
      end
   endfunction

   // Mirror starts with the same address-derived pattern as the memory
   initial begin
      int w;
      for (w = 0; w < DEPTH; w++) begin
         mirror[w] = ((w << 2) * 32'h9E3779B1) ^ 32'h3C6EF372;
      end
   end

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Writeback ready with random stalls, forced low during the hold test
   initial begin
      stall_seed     = TB_SEED;
      wb_mu_in_ready = 1'b0;
      forever begin
         @(negedge clk);
         wb_mu_in_ready = hold_wb ? 1'b0 : (($random(stall_seed) & 3) != 0);
      end
   end

   // Reference model and checks on every rising edge
   always @(posedge clk) begin
      exp_t e;
      int   wi;
      if (!rst) begin
         // Response channel passes straight between bus and writeback
         assert (dbus_ready == wb_mu_in_ready)
            else report_fail("bus response ready does not follow writeback ready");
         assert (wb_mu_in_valid == dbus_valid)
            else report_fail("writeback valid does not follow bus response valid");

         // Nothing new accepted while a transaction is outstanding
         if (exp_q.size() != 0) begin
            assert (!ieu_mu_in_ready) else report_fail("issue ready high while pending");
         end
         assert (!(wb_mu_in_valid && exp_q.size() == 0))
            else report_fail("writeback valid with no outstanding op");

         // Response stays put under back-pressure
         if (hold_valid) begin
            assert (wb_mu_in_valid) else report_fail("writeback valid dropped before ready");
            assert (mu_load == held_load) else report_fail("load data changed under stall");
         end
         if (wb_mu_in_valid && !wb_mu_in_ready) begin
            hold_valid = 1'b1;
            held_load  = mu_load;
         end else begin
            hold_valid = 1'b0;
         end

         // Writeback handshake
         if (wb_mu_in_valid && wb_mu_in_ready && exp_q.size() != 0) begin
            e = exp_q.pop_front();
            assert (mu_op) else report_fail("mu_op low on writeback");
            assert (mu_op_load == e.load) else report_fail("mu_op_load mismatch");
            assert (mu_wb_regf == e.regf) else report_fail("mu_wb_regf mismatch");
            assert (mu_wb_reg_addr == e.tag) else report_fail("mu_wb_reg_addr mismatch");
            if (e.load) begin
               assert (mu_load == e.data)
                  else report_fail($sformatf("load got %h expected %h", mu_load, e.data));
            end
         end

         // Issue acceptance of a memory op is a command acceptance
         if (ieu_mu_in_valid && ieu_mu_in_ready && (ieu_mu_load || ieu_mu_store)) begin
            assert (dbus_cmd_valid) else report_fail("command valid low on memory op");
            assert (dbus_cmd_addr == cur_addr)
               else report_fail("bus address is not operand 1 plus operand 2");
            assert (dbus_cmd_we == ieu_mu_store) else report_fail("write enable mismatch");
            assert (dbus_cmd_size == cur_size) else report_fail("bus size mismatch");
            if (ieu_mu_store) begin
               assert (dbus_din == ieu_operand_3) else report_fail("store data mismatch");
            end
            wi     = (cur_addr >> 2) % DEPTH;
            e.load = ieu_mu_load;
            e.regf = ieu_wb_regf;
            e.tag  = ieu_wb_reg_addr;
            e.data = extend(mirror[wi], ieu_mu_load_size, ieu_mu_sign_ext);
            if (ieu_mu_store) begin
               mirror[wi] = ieu_operand_3;
            end
            exp_q.push_back(e);
         end
      end
   end

   // Present one op and hold it until the unit takes it
   task automatic issue_op(input logic ld, input logic st, input mu_pkg::size_t lsz,
                           input mu_pkg::size_t ssz, input logic sx, input mu_pkg::data_t op1,
                           input mu_pkg::data_t op2, input mu_pkg::data_t op3,
                           input mu_pkg::reg_addr_t tag);
      integer t;
      logic   regf;
      begin
         regf = $random(seed);
         @(negedge clk);
         ieu_operand_1     = op1;
         ieu_operand_2     = op2;
         ieu_operand_3     = op3;
         ieu_mu_load       = ld;
         ieu_mu_store      = st;
         ieu_mu_load_size  = lsz;
         ieu_mu_store_size = ssz;
         ieu_mu_sign_ext   = sx;
         ieu_wb_regf       = regf;
         ieu_wb_reg_addr   = tag;
         ieu_mu_in_valid   = 1'b1;
         t = 0;
         while (!ieu_mu_in_ready && t < TMO) begin
            @(negedge clk);
            t++;
         end
         if (t >= TMO) begin
            report_timeout("issue ready");
         end
         // Pass-through op shows its tag at once
         if (!ld && !st) begin
            #1;
            assert (!mu_op) else report_fail("mu_op high on non-memory op");
            assert (mu_wb_reg_addr == tag) else report_fail("non-memory tag not shown");
            assert (mu_wb_regf == regf) else report_fail("non-memory regf not shown");
            assert (!dbus_cmd_valid) else report_fail("bus command on non-memory op");
            assert (!wb_mu_in_valid) else report_fail("writeback on non-memory op");
         end
         @(negedge clk);
         ieu_mu_in_valid = 1'b0;
         ieu_mu_load     = 1'b0;
         ieu_mu_store    = 1'b0;
      end
   endtask

   // Memory op at a chosen address with a random split into base and offset
   // The unused size input carries a different code so the size choice is visible
   task automatic mem_access(input logic st, input mu_pkg::size_t sz, input logic sx,
                             input mu_pkg::addr_t addr, input mu_pkg::data_t wdata);
      mu_pkg::data_t op1;
      mu_pkg::size_t other;
      begin
         op1      = $random(seed);
         other    = (sz == mu_pkg::SIZE_WORD) ? mu_pkg::SIZE_BYTE : mu_pkg::SIZE_WORD;
         cur_addr = addr;
         cur_size = sz;
         issue_op(!st, st, st ? other : sz, st ? sz : other, sx, op1, addr - op1, wdata,
                  $random(seed));
      end
   endtask

   task automatic wait_idle;
      integer t;
      begin
         t = 0;
         while ((exp_q.size() != 0 || wb_mu_in_valid) && t < TMO) begin
            @(negedge clk);
            t++;
         end
         if (t >= TMO) begin
            report_timeout("outstanding transaction to finish");
         end
      end
   endtask

   function automatic mu_pkg::size_t pick_size(input int r);
      begin
         case (r & 3)
            0:       pick_size = mu_pkg::SIZE_BYTE;
            1:       pick_size = mu_pkg::SIZE_HALF;
            default: pick_size = mu_pkg::SIZE_WORD;
         endcase
      end
   endfunction

   initial begin
      mu_pkg::addr_t a;
      mu_pkg::data_t d;
      integer        t;
      seed              = TB_SEED;
      err_count         = 0;
      timeout_count     = 0;
      hold_wb           = 1'b0;
      hold_valid        = 1'b0;
      held_load         = '0;
      cur_addr          = '0;
      cur_size          = '0;
      rst               = 1'b1;
      ieu_mu_in_valid   = 1'b0;
      ieu_operand_1     = '0;
      ieu_operand_2     = '0;
      ieu_operand_3     = '0;
      ieu_mu_load       = 1'b0;
      ieu_mu_store      = 1'b0;
      ieu_mu_sign_ext   = 1'b0;
      ieu_mu_store_size = '0;
      ieu_mu_load_size  = '0;
      ieu_wb_regf       = 1'b0;
      ieu_wb_reg_addr   = '0;

      // Reset for 16 cycles, then a few idle cycles
      for (k = 0; k < 20; k++) begin
         @(negedge clk);
         if (k == 15) begin
            rst = 1'b0;
         end
         if (k > 0) begin
            assert (ieu_mu_in_ready == dbus_cmd_ready)
               else report_fail("issue ready differs from bus ready after reset");
            assert (!wb_mu_in_valid) else report_fail("writeback valid during reset");
         end
      end

      // Word loads
      for (k = 0; k < 8; k++) begin
         mem_access(1'b0, mu_pkg::SIZE_WORD, 1'b0, $random(seed) & 32'h3FF, '0);
      end

      // Plant words with both sign bits set, then byte and half loads
      for (k = 0; k < 4; k++) begin
         mem_access(1'b1, mu_pkg::SIZE_WORD, 1'b0, 32'h40 + 4 * k, 32'hFFFF8080 ^ (k << 4));
      end
      for (k = 0; k < 24; k++) begin
         a = (k < 8) ? (32'h40 + 4 * (k & 3)) : ($random(seed) & 32'h3FF);
         mem_access(1'b0, pick_size(k), k[2], a, '0);
      end

      // Stores read back as words
      for (k = 0; k < 8; k++) begin
         a = $random(seed) & 32'h3FC;
         d = $random(seed);
         mem_access(1'b1, pick_size($random(seed)), 1'b0, a, d);
         mem_access(1'b0, mu_pkg::SIZE_WORD, 1'b0, a, '0);
      end

      // Writeback held off for several cycles
      wait_idle();
      hold_wb = 1'b1;
      mem_access(1'b0, mu_pkg::SIZE_WORD, 1'b0, 32'h84, '0);
      t = 0;
      while (!wb_mu_in_valid && t < TMO) begin
         @(negedge clk);
         t++;
      end
      if (t >= TMO) begin
         report_timeout("writeback valid in the stall test");
      end
      repeat (6) @(negedge clk);
      hold_wb = 1'b0;

      // Non-memory ops pass straight through
      for (k = 0; k < 6; k++) begin
         wait_idle();
         issue_op(1'b0, 1'b0, '0, '0, 1'b0, $random(seed), $random(seed), $random(seed),
                  $random(seed));
      end

      // Random mix
      for (k = 0; k < 40; k++) begin
         mem_access($random(seed), pick_size($random(seed)), $random(seed),
                    $random(seed) & 32'h3FF, $random(seed));
      end

      wait_idle();
      repeat (4) @(negedge clk);
      $display("Errors: %0d, timeouts: %0d", err_count, timeout_count);
      if (err_count == 0 && timeout_count == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule
